//--- Bender.yml
package:
  name: us_acq

export_include_dirs:
  - rtl

sources:
  # acquisition core
  - include_dirs:
      - rtl
    files:
      - rtl/us_acq_pkg.sv
      - rtl/fire_delay_pulser.sv
      - rtl/acq_sequencer.sv
      - rtl/channel_capture.sv
      - rtl/us_acq_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/acq_checker.sv
      - testbench/tb_us_acq.sv

//--- all.f
+incdir+rtl
rtl/us_acq_pkg.sv
rtl/fire_delay_pulser.sv
rtl/acq_sequencer.sv
rtl/channel_capture.sv
rtl/us_acq_top.sv
testbench/acq_checker.sv
testbench/tb_us_acq.sv

//--- rtl/acq_sequencer.sv
// ==========================================================
// shot sequencer for one ultrasound firing
// latches tx_len, init_delay and samples_per_echo at start,
// then walks pulse, delay and window with one down-counter
// a zero count skips its phase; done lasts one cycle
// tx_pulse and acq_done are registered decodes of the state
// ==========================================================

`timescale 1ns/1ps

`include "us_acq_consts.svh"

module acq_sequencer
(
	input  logic                     ADC_CLKOUT,
	input  logic                     rst_n,
	input  logic                     acq_start,        // one-cycle pulse
	input  logic [`US_ACQ_CNT_W-1:0] tx_len,           // transmit pulse cycles
	input  logic [`US_ACQ_CNT_W-1:0] init_delay,       // quiet cycles before capture
	input  logic [`US_ACQ_CNT_W-1:0] samples_per_echo, // capture window length
	output logic                     tx_pulse,
	output us_acq_pkg::acq_state_e   acq_state,        // window qualifier for capture
	output logic                     acq_done          // one-cycle pulse
);

	import us_acq_pkg::*;

	acq_state_e state;
	acq_state_e state_nxt;

	logic [`US_ACQ_CNT_W-1:0] cnt;      // cycles left in current phase
	logic [`US_ACQ_CNT_W-1:0] cnt_nxt;

	// config held for the whole shot
	logic [`US_ACQ_CNT_W-1:0] tx_len_q;
	logic [`US_ACQ_CNT_W-1:0] init_delay_q;
	logic [`US_ACQ_CNT_W-1:0] samples_q;

	// live inputs while idle, latched copy afterwards
	logic [`US_ACQ_CNT_W-1:0] cfg_tx;
	logic [`US_ACQ_CNT_W-1:0] cfg_dly;
	logic [`US_ACQ_CNT_W-1:0] cfg_smp;

	// first phase after cur with a nonzero count, else done
	function automatic acq_state_e next_phase
	(
		input acq_state_e cur,
		input logic       tx_nz,
		input logic       dly_nz,
		input logic       smp_nz
	);
		next_phase = ACQ_DONE;
		case (cur)
			ACQ_IDLE:
			begin
				if (tx_nz)
					next_phase = ACQ_PULSE;
				else if (dly_nz)
					next_phase = ACQ_DELAY;
				else if (smp_nz)
					next_phase = ACQ_WINDOW;
			end
			ACQ_PULSE:
			begin
				if (dly_nz)
					next_phase = ACQ_DELAY;
				else if (smp_nz)
					next_phase = ACQ_WINDOW;
			end
			ACQ_DELAY:
			begin
				if (smp_nz)
					next_phase = ACQ_WINDOW;
			end
			default: next_phase = ACQ_DONE; // window always ends in done
		endcase
	endfunction

	// ==========================================================
	// next state and counter
	// ==========================================================
	always_comb
	begin
		cfg_tx  = (state == ACQ_IDLE) ? tx_len           : tx_len_q;
		cfg_dly = (state == ACQ_IDLE) ? init_delay       : init_delay_q;
		cfg_smp = (state == ACQ_IDLE) ? samples_per_echo : samples_q;

		state_nxt = state;
		cnt_nxt   = cnt;

		case (state)
			ACQ_IDLE:
			begin
				if (acq_start)
					state_nxt = next_phase(state, |cfg_tx, |cfg_dly, |cfg_smp);
			end
			ACQ_PULSE, ACQ_DELAY, ACQ_WINDOW:
			begin
				if (cnt == `US_ACQ_CNT_W'(1))
					state_nxt = next_phase(state, |cfg_tx, |cfg_dly, |cfg_smp);
				else
					cnt_nxt = cnt - 1'b1;
			end
			ACQ_DONE: state_nxt = ACQ_IDLE;
			default:  state_nxt = ACQ_IDLE;
		endcase

		// load the length of the phase being entered
		if (state_nxt != state)
		begin
			case (state_nxt)
				ACQ_PULSE:  cnt_nxt = cfg_tx;
				ACQ_DELAY:  cnt_nxt = cfg_dly;
				ACQ_WINDOW: cnt_nxt = cfg_smp;
				default:    cnt_nxt = '0;
			endcase
		end
	end

	// ==========================================================
	// state and output registers
	// ==========================================================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (!rst_n)
		begin
			state    <= ACQ_IDLE;
			cnt      <= '0;
			tx_pulse <= 1'b0;
			acq_done <= 1'b0;
		end
		else
		begin
			state    <= state_nxt;
			cnt      <= cnt_nxt;
			tx_pulse <= (state == ACQ_PULSE); // one cycle behind state, like ch_valid
			acq_done <= (state == ACQ_DONE);
		end
	end

	// config snapshot at shot start, later changes wait for the next shot
	always_ff @(posedge ADC_CLKOUT)
	begin
		if ((state == ACQ_IDLE) && acq_start)
		begin
			tx_len_q     <= tx_len;
			init_delay_q <= init_delay;
			samples_q    <= samples_per_echo;
		end
	end

	assign acq_state = state;

endmodule

//--- rtl/channel_capture.sv
// ==========================================================
// eight-lane capture stage
// registers every adc lane into a 16-bit channel word while
// the sequencer is in its window state, ch_valid one cycle
// later; outside the window the words hold their last value
// ==========================================================

`timescale 1ns/1ps

`include "us_acq_consts.svh"

module channel_capture
(
	input  logic                                       ADC_CLKOUT,
	input  logic                                       rst_n,
	input  us_acq_pkg::acq_state_e                     acq_state,
	input  logic [`US_ACQ_NUM_CH*`US_ACQ_SAMPLE_W-1:0] adc_data, // lane 0 in low bits
	output logic [`US_ACQ_NUM_CH*`US_ACQ_WORD_W-1:0]   ch_data,
	output logic                                       ch_valid
);

	import us_acq_pkg::*;

	channel_word_u word_q [`US_ACQ_NUM_CH]; // one word per lane

	logic in_window;

	assign in_window = (acq_state == ACQ_WINDOW);

	// ==========================================================
	// lane registers
	// ==========================================================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (!rst_n)
		begin
			ch_valid <= 1'b0;
			for (int i = 0; i < `US_ACQ_NUM_CH; i++)
				word_q[i] <= '0; // ch_data reads zero out of reset
		end
		else
		begin
			ch_valid <= in_window;
			if (in_window)
			begin
				for (int i = 0; i < `US_ACQ_NUM_CH; i++)
				begin
					word_q[i].fields.pad    <= '0;
					word_q[i].fields.sample <= adc_data[i*`US_ACQ_SAMPLE_W +: `US_ACQ_SAMPLE_W];
				end
			end
		end
	end

	// flatten raw words onto the output bus
	for (genvar g = 0; g < `US_ACQ_NUM_CH; g++)
	begin : g_lane
		assign ch_data[g*`US_ACQ_WORD_W +: `US_ACQ_WORD_W] = word_q[g].raw;
	end

endmodule

//--- rtl/fire_delay_pulser.sv
// ==========================================================
// host firing endpoint, four-phase fire_req / fire_ack
// an accepted request gives one acq_start pulse after the
// fixed fire delay; acq_done from the sequencer raises
// fire_ack, held until the host drops fire_req
// ==========================================================

`timescale 1ns/1ps

`include "us_acq_consts.svh"

module fire_delay_pulser
(
	input  logic ADC_CLKOUT,
	input  logic rst_n,
	input  logic fire_req,  // host request, held until ack
	output logic fire_ack,  // shot finished
	input  logic acq_done,  // one-cycle pulse from sequencer
	output logic acq_start  // one-cycle pulse to sequencer
);

	// counter only needs to reach FIRE_DELAY-2
	localparam int DLY_W = ($clog2(`US_ACQ_FIRE_DELAY) > 0) ? $clog2(`US_ACQ_FIRE_DELAY) : 1;

	typedef enum logic [1:0]
	{
		PL_IDLE = 2'd0, // ready for a new request
		PL_WAIT = 2'd1, // counting the fire delay
		PL_BUSY = 2'd2, // shot running, wait for acq_done
		PL_ACK  = 2'd3  // ack high until request released
	} pl_state_e;

	pl_state_e        state;
	logic [DLY_W-1:0] dly_cnt;

	// ==========================================================
	// handshake fsm
	// ==========================================================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (!rst_n)
		begin
			state   <= PL_IDLE;
			dly_cnt <= '0;
		end
		else
		begin
			case (state)
				PL_IDLE:
				begin
					// only reachable with fire_req low after an ack, so a level
					// here is always a fresh request
					if (fire_req)
					begin
						state   <= PL_WAIT;
						dly_cnt <= DLY_W'(`US_ACQ_FIRE_DELAY - 2);
					end
				end
				PL_WAIT:
				begin
					if (dly_cnt == '0)
						state <= PL_BUSY; // acq_start goes out this cycle
					else
						dly_cnt <= dly_cnt - 1'b1;
				end
				PL_BUSY:
				begin
					if (acq_done)
						state <= PL_ACK;
				end
				PL_ACK:
				begin
					if (!fire_req)
						state <= PL_IDLE; // ack drops next cycle
				end
				default: state <= PL_IDLE;
			endcase
		end
	end

	// decoded straight from the state flops
	assign acq_start = (state == PL_WAIT) && (dly_cnt == '0);
	assign fire_ack  = (state == PL_ACK);

endmodule

//--- rtl/us_acq_consts.svh
// ==========================================================
// shared constants for the ultrasound acquisition core
// lane count, sample and word widths, timing count width
// and the request-to-start delay of the firing pulser
// include wherever a width or the fire delay is needed
// ==========================================================

`ifndef US_ACQ_CONSTS_SVH
`define US_ACQ_CONSTS_SVH

// ==========================================================
// adc lanes
// ==========================================================
`define US_ACQ_NUM_CH     8   // parallel adc lanes, one per channel
`define US_ACQ_SAMPLE_W   14  // raw adc sample bits
`define US_ACQ_WORD_W     16  // channel word, sample zero-padded on top

// ==========================================================
// shot timing
// ==========================================================
// tx_len, init_delay and samples_per_echo all share this width
`define US_ACQ_CNT_W      32

// accepted request to acq_start, in ADC_CLKOUT cycles
// must be at least 2 for the pulser counter
`define US_ACQ_FIRE_DELAY 10

`endif

//--- rtl/us_acq_pkg.sv
// ==========================================================
// types shared by the acquisition core
// channel word with raw and sample views, sequencer states
// import with us_acq_pkg::* inside a module body
// ==========================================================

`include "us_acq_consts.svh"

package us_acq_pkg;

	// ======================================================
	// channel word
	// ======================================================
	// capture writes the sample view, sink reads the raw word
	typedef struct packed
	{
		logic [`US_ACQ_WORD_W-`US_ACQ_SAMPLE_W-1:0] pad; // always zero
		logic [`US_ACQ_SAMPLE_W-1:0]               sample; // adc lane value
	} channel_fields_t;

	typedef union packed
	{
		logic [`US_ACQ_WORD_W-1:0] raw; // as the downstream sink takes it
		channel_fields_t           fields;
	} channel_word_u;

	// ======================================================
	// sequencer states
	// ======================================================
	typedef enum logic [2:0]
	{
		ACQ_IDLE   = 3'd0, // waiting for acq_start
		ACQ_PULSE  = 3'd1, // transmit pulse phase
		ACQ_DELAY  = 3'd2, // initial delay before capture
		ACQ_WINDOW = 3'd3, // capture window, one sample per cycle
		ACQ_DONE   = 3'd4  // one cycle, raises acq_done
	} acq_state_e;

endpackage

//--- rtl/us_acq_top.sv
// ==========================================================
// ultrasound acquisition core, single ADC_CLKOUT domain
// host fires a shot with fire_req / fire_ack, the pulser
// delays it, the sequencer runs pulse, delay and window,
// and the capture stage presents eight padded channel words
// ==========================================================

`timescale 1ns/1ps

`include "us_acq_consts.svh"

module us_acq_top
(
	input  logic                                       ADC_CLKOUT,
	input  logic                                       rst_n,

	// host firing handshake
	input  logic                                       fire_req,
	output logic                                       fire_ack,

	// shot configuration, sampled at shot start
	input  logic [`US_ACQ_CNT_W-1:0]                   tx_len,
	input  logic [`US_ACQ_CNT_W-1:0]                   init_delay,
	input  logic [`US_ACQ_CNT_W-1:0]                   samples_per_echo,

	// adc lanes in, transmit and channel data out
	input  logic [`US_ACQ_NUM_CH*`US_ACQ_SAMPLE_W-1:0] adc_data,
	output logic                                       tx_pulse,
	output logic [`US_ACQ_NUM_CH*`US_ACQ_WORD_W-1:0]   ch_data,
	output logic                                       ch_valid
);

	import us_acq_pkg::*;

	logic       acq_start; // pulser -> sequencer
	logic       acq_done;  // sequencer -> pulser
	acq_state_e acq_state; // sequencer -> capture

	// ==========================================================
	// blocks
	// ==========================================================
	fire_delay_pulser i_pulser
	(
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst_n      (rst_n),
		.fire_req   (fire_req),
		.fire_ack   (fire_ack),
		.acq_done   (acq_done),
		.acq_start  (acq_start)
	);

	acq_sequencer i_seq
	(
		.ADC_CLKOUT       (ADC_CLKOUT),
		.rst_n            (rst_n),
		.acq_start        (acq_start),
		.tx_len           (tx_len),
		.init_delay       (init_delay),
		.samples_per_echo (samples_per_echo),
		.tx_pulse         (tx_pulse),
		.acq_state        (acq_state),
		.acq_done         (acq_done)
	);

	// no ready from the sink, data goes out whether taken or not
	channel_capture i_capture
	(
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst_n      (rst_n),
		.acq_state  (acq_state),
		.adc_data   (adc_data),
		.ch_data    (ch_data),
		.ch_valid   (ch_valid)
	);

endmodule

//--- testbench/acq_checker.sv
// ==========================================================
// shot checker for the acquisition core
// follows each shot from the first sampled fire_req and
// predicts tx_pulse, ch_valid and fire_ack for every cycle
// each valid word is checked against last cycle's adc_data
// ==========================================================

`timescale 1ns/1ps

`include "us_acq_consts.svh"

module acq_checker
(
	input  logic                                       ADC_CLKOUT,
	input  logic                                       rst_n,
	input  logic                                       fire_req,
	input  logic                                       fire_ack,
	input  logic [`US_ACQ_CNT_W-1:0]                   tx_len,
	input  logic [`US_ACQ_CNT_W-1:0]                   init_delay,
	input  logic [`US_ACQ_CNT_W-1:0]                   samples_per_echo,
	input  logic [`US_ACQ_NUM_CH*`US_ACQ_SAMPLE_W-1:0] adc_data,
	input  logic                                       tx_pulse,
	input  logic [`US_ACQ_NUM_CH*`US_ACQ_WORD_W-1:0]   ch_data,
	input  logic                                       ch_valid,
	output int                                         error_count,
	output int                                         shot_count,
	output int                                         word_count
);

	localparam int ADC_W    = `US_ACQ_NUM_CH*`US_ACQ_SAMPLE_W;
	localparam int DATA_W   = `US_ACQ_NUM_CH*`US_ACQ_WORD_W;
	localparam int TX_FIRST = `US_ACQ_FIRE_DELAY + 1; // request sample to first tx_pulse

	int errs  = 0;
	int shots = 0;
	int words = 0;

	logic              in_shot;   // between request and release
	longint            n;         // samples since request, request is 0
	longint            t_len;     // config seen with the request
	longint            d_len;
	longint            s_len;
	longint            v_first;   // first ch_valid sample
	logic              tx_exp;
	logic              valid_exp;
	logic              ack_exp;
	logic [DATA_W-1:0] last_word; // zero until the first valid
	logic [DATA_W-1:0] exp_word;
	logic [ADC_W-1:0]  prev_adc;  // lanes seen one sample earlier

	assign error_count = errs;
	assign shot_count  = shots;
	assign word_count  = words;

	// 14-bit lane into the low bits of a 16-bit word, top bits zero
	function automatic logic [DATA_W-1:0] pad_lanes(input logic [ADC_W-1:0] adc);
		logic [DATA_W-1:0] w;
		w = '0;
		for (int i = 0; i < `US_ACQ_NUM_CH; i++)
			w[i*`US_ACQ_WORD_W +: `US_ACQ_SAMPLE_W] = adc[i*`US_ACQ_SAMPLE_W +: `US_ACQ_SAMPLE_W];
		return w;
	endfunction

	task automatic mismatch(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		$display("Mismatch %s: expected %0h, actual %0h (shot %0d, cycle %0d)",
			name, exp, act, shots, n);
		errs++;
	endtask

	// ==========================================================
	// per-cycle model, sampled at the rising edge
	// ==========================================================
	always @(posedge ADC_CLKOUT)
	begin
		if (!rst_n)
		begin
			in_shot   = 1'b0;
			last_word = '0;
		end
		else
		begin
			if (!in_shot && fire_req)
			begin
				in_shot = 1'b1; // fresh request, cycle 0
				n       = 0;
				t_len   = tx_len;
				d_len   = init_delay;
				s_len   = samples_per_echo;
				shots++;
			end
			v_first   = TX_FIRST + t_len + d_len;
			tx_exp    = in_shot && (n >= TX_FIRST) && (n < TX_FIRST + t_len);
			valid_exp = in_shot && (n >= v_first) && (n < v_first + s_len);
			ack_exp   = in_shot && (n > v_first + s_len); // two after last valid

			if (tx_pulse !== tx_exp)
				mismatch("tx_pulse", tx_exp, tx_pulse);
			if (ch_valid !== valid_exp)
				mismatch("ch_valid", valid_exp, ch_valid);
			if (fire_ack !== ack_exp)
				mismatch("fire_ack", ack_exp, fire_ack);

			if (valid_exp)
			begin
				exp_word = pad_lanes(prev_adc);
				words++;
			end
			else
				exp_word = last_word; // words hold outside the window
			if (ch_data !== exp_word)
				mismatch("ch_data", exp_word, ch_data);
			last_word = exp_word;

			if (in_shot && !fire_req)
			begin
				if (!ack_exp)
				begin
					$display("fire_req was dropped before fire_ack rose (shot %0d)", shots);
					errs++;
				end
				in_shot = 1'b0; // ack falls, idle from the next sample
			end
			n++;
		end
		prev_adc = adc_data;
	end

endmodule

//--- testbench/tb_us_acq.sv
// ==========================================================
// testbench for the acquisition core
// fires random shots over the req/ack pair with LFSR-picked
// timing counts, new adc lanes every cycle, random gaps and
// mid-shot config changes; acq_checker does the comparing
// ==========================================================

`timescale 1ns/1ps

`include "us_acq_consts.svh"

module tb_us_acq;

	localparam int ADC_W     = `US_ACQ_NUM_CH*`US_ACQ_SAMPLE_W;
	localparam int DATA_W    = `US_ACQ_NUM_CH*`US_ACQ_WORD_W;
	localparam int NUM_SHOTS = 48;
	localparam int ACK_LIMIT = 400; // cycles, longest shot is about 45

	logic                     ADC_CLKOUT = 1'b0;
	logic                     rst_n;
	logic                     fire_req;
	logic                     fire_ack;
	logic [`US_ACQ_CNT_W-1:0] tx_len;
	logic [`US_ACQ_CNT_W-1:0] init_delay;
	logic [`US_ACQ_CNT_W-1:0] samples_per_echo;
	logic [ADC_W-1:0]         adc_data;
	logic                     tx_pulse;
	logic [DATA_W-1:0]        ch_data;
	logic                     ch_valid;

	logic [31:0] lfsr        = 32'h1be74301;
	int          tb_errors   = 0;
	int          shots_fired = 0;
	bit          aborted     = 1'b0;
	int          wait_cnt;
	int          chk_errors;
	int          chk_shots;
	int          chk_words;

	always #2 ADC_CLKOUT = ~ADC_CLKOUT; // 4 ns period

	us_acq_top i_dut (.*);

	acq_checker i_checker (.*, .error_count(chk_errors), .shot_count(chk_shots),
		.word_count(chk_words));

	// x^32 + x^22 + x^2 + x + 1, shift left, new bit in at 0
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// next edge, then new lanes 1 ns later
	task automatic step_cycle;
		@(posedge ADC_CLKOUT);
		#1;
		for (int i = 0; i < `US_ACQ_NUM_CH; i++)
			adc_data[i*`US_ACQ_SAMPLE_W +: `US_ACQ_SAMPLE_W] = take_bits(`US_ACQ_SAMPLE_W);
	endtask

	// ==========================================================
	// one shot, four-phase handshake
	// ==========================================================
	task automatic run_shot;
		int hold;
		int gap;
		tx_len           = take_bits(3); // zeros included
		init_delay       = take_bits(3);
		samples_per_echo = take_bits(4);
		fire_req         = 1'b1;
		shots_fired++;
		repeat (`US_ACQ_FIRE_DELAY + 2) step_cycle(); // past shot start
		if (take_bits(1))
		begin
			tx_len           = take_bits(8); // must not touch this shot
			init_delay       = take_bits(8);
			samples_per_echo = take_bits(8);
		end
		wait_cnt = 0;
		while (!fire_ack && wait_cnt < ACK_LIMIT)
		begin
			step_cycle();
			wait_cnt++;
		end
		if (!fire_ack)
		begin
			$display("timeout, fire_ack did not rise within %0d cycles (shot %0d)",
				ACK_LIMIT, shots_fired);
			tb_errors++;
			aborted = 1'b1;
			return;
		end
		hold = take_bits(2);
		repeat (hold) step_cycle(); // request held across the ack
		fire_req = 1'b0;
		wait_cnt = 0;
		while (fire_ack && wait_cnt < ACK_LIMIT)
		begin
			step_cycle();
			wait_cnt++;
		end
		if (fire_ack)
		begin
			$display("timeout, fire_ack stayed high after fire_req fell (shot %0d)", shots_fired);
			tb_errors++;
			aborted = 1'b1;
			return;
		end
		gap = take_bits(3);
		repeat (gap) step_cycle();
	endtask

	initial
	begin
		rst_n            = 1'b0;
		fire_req         = 1'b0;
		tx_len           = '0;
		init_delay       = '0;
		samples_per_echo = '0;
		adc_data         = '0;
		repeat (5) step_cycle(); // 5 edges in reset
		rst_n = 1'b1;
		repeat (3) step_cycle(); // idle outputs checked here
		for (int s = 0; s < NUM_SHOTS && !aborted; s++)
			run_shot();
		repeat (4) step_cycle();
		if (!aborted && chk_shots != shots_fired)
		begin
			$display("checker counted %0d shots but %0d were fired", chk_shots, shots_fired);
			tb_errors++;
		end
		if (chk_words == 0)
		begin
			$display("no valid channel word was seen in any shot");
			tb_errors++;
		end
		$display("checker errors: %0d, testbench errors: %0d, shots: %0d, words: %0d",
			chk_errors, tb_errors, chk_shots, chk_words);
		if (chk_errors + tb_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
